//--- compile.f
+incdir+src
src/cpu_pkg.sv
src/memory2_stage.sv
src/writeback_stage.sv
src/regfile.sv
src/cpu_backend.sv
dv/cpu_backend_assert.sv
dv/cpu_backend_tb.sv

//--- dv/cpu_backend_tb.sv
`timescale 1ns/1ps
`include "cpu_defs_macros.svh"

module cpu_backend_tb;

    localparam int XLEN        = `CPU_XLEN;
    localparam int IDX_W       = `CPU_REG_IDX_W;
    localparam int CLK_PERIOD  = 20;
    localparam int LFSR_SEED   = 82;
    localparam int DRAIN_LIMIT = 20;

    localparam int MODE_ALU   = 0;
    localparam int MODE_LOAD  = 1;
    localparam int MODE_LINK  = 2;
    localparam int MODE_MIXED = 3;

    localparam int N_ALU   = 40;
    localparam int N_LOAD  = 40;
    localparam int N_LINK  = 24;
    localparam int N_BP    = 60;
    localparam int N_FLUSH = 60;
    localparam int TOTAL_ITEMS = N_ALU + N_LOAD + N_LINK + N_BP + N_FLUSH;
    localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 40;

    logic                   clk;
    logic                   rst_n;
    logic                   flush;
    cpu_pkg::ex_mem2_pass_t in_pass;
    logic                   in_ready;
    logic                   commit_valid;
    cpu_pkg::commit_t       commit;
    logic                   commit_ready;
    logic [IDX_W-1:0]       raddr_a;
    logic [IDX_W-1:0]       raddr_b;
    logic [XLEN-1:0]        rdata_a;
    logic [XLEN-1:0]        rdata_b;

    cpu_pkg::commit_t expected[$];
    logic [XLEN-1:0]  mirror [`CPU_NREGS];
    logic [31:0]      lfsr_state;
    logic [XLEN-1:0]  next_pc;
    int               checks;
    int               errors;
    bit               ready_random;
    bit               flush_enable;
    int               flush_at;

    cpu_backend cpu_backend_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .in_pass      (in_pass),
        .in_ready     (in_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready),
        .raddr_a      (raddr_a),
        .raddr_b      (raddr_b),
        .rdata_a      (rdata_a),
        .rdata_b      (rdata_b)
    );

    bind cpu_backend cpu_backend_assert cpu_backend_assert_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_pass      (in_pass),
        .in_ready     (in_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready),
        .raddr_a      (raddr_a),
        .rdata_a      (rdata_a)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Right-shift Galois LFSR, one step per returned bit.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'hA300_0000;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    function automatic int assert_errors();
        return int'(cpu_backend_i.cpu_backend_assert_i.in_hold_errors)
             + int'(cpu_backend_i.cpu_backend_assert_i.commit_hold_errors)
             + int'(cpu_backend_i.cpu_backend_assert_i.reg_write_errors)
             + int'(cpu_backend_i.cpu_backend_assert_i.r0_errors);
    endfunction

    function automatic int total_errors();
        return errors + assert_errors();
    endfunction

    // The expected commit record picks the little-endian lane, extends it
    // per load kind, and takes pc+4 for links over everything else.
    function automatic cpu_pkg::commit_t model_commit(input cpu_pkg::ex_mem2_pass_t p);
        cpu_pkg::commit_t c;
        logic [XLEN-1:0]  lane;
        logic [XLEN-1:0]  half;
        lane = p.ld_word >> (8 * p.addr_lo);
        half = p.ld_word >> (16 * p.addr_lo[1]);
        c.pc    = p.pc;
        c.wen   = p.is_wr_rd;
        c.wdest = p.rd;
        case (p.ld_kind)
            cpu_pkg::LD_B:  c.wdata = {{(XLEN - 8){lane[7]}}, lane[7:0]};
            cpu_pkg::LD_BU: c.wdata = {{(XLEN - 8){1'b0}}, lane[7:0]};
            cpu_pkg::LD_H:  c.wdata = {{(XLEN - 16){half[15]}}, half[15:0]};
            cpu_pkg::LD_HU: c.wdata = {{(XLEN - 16){1'b0}}, half[15:0]};
            cpu_pkg::LD_W:  c.wdata = p.ld_word;
            default:        c.wdata = p.ex_out;
        endcase
        if (p.is_link) begin
            c.wdata = p.pc + 32'd4;
        end
        return c;
    endfunction

    function automatic cpu_pkg::ex_mem2_pass_t make_item(input int mode, input int idx);
        cpu_pkg::ex_mem2_pass_t p;
        p          = '0;
        p.valid    = 1'b1;
        p.pc       = next_pc;
        next_pc    = next_pc + 32'd4;
        p.rd       = IDX_W'(take_bits(IDX_W));
        p.is_wr_rd = 1'b1;
        p.ld_kind  = cpu_pkg::LD_NONE;
        p.addr_lo  = 2'(take_bits(2));
        p.ex_out   = take_bits(32);
        p.ld_word  = take_bits(32);
        case (mode)
            MODE_LOAD: begin
                // Walk all kind and lane pairs in turn.
                p.ld_kind = cpu_pkg::ld_kind_t'(3'(1 + idx % 5));
                p.addr_lo = 2'((idx % 20) / 5);
            end
            MODE_LINK: begin
                p.is_link = 1'b1;
                if (idx % 4 == 0) begin
                    p.rd = '0;
                end
            end
            MODE_MIXED: begin
                p.is_wr_rd = 1'(take_bits(1));
                p.is_link  = (take_bits(3) == 0);
                p.ld_kind  = cpu_pkg::ld_kind_t'(3'(take_bits(3) % 6));
            end
            default: begin
            end
        endcase
        return p;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic drive_side_inputs();
        commit_ready <= ready_random ? 1'(take_bits(1)) : 1'b1;
        raddr_a      <= IDX_W'(take_bits(IDX_W));
        raddr_b      <= IDX_W'(take_bits(IDX_W));
        if (flush_at == 0) begin
            flush    <= 1'b1;
            flush_at = flush_enable ? 3 + int'(take_bits(4)) : -1;
        end else begin
            flush <= 1'b0;
            if (flush_at > 0) begin
                flush_at--;
            end
        end
    endtask

    task automatic send_item(input cpu_pkg::ex_mem2_pass_t p);
        in_pass <= p;
        do begin
            @(posedge clk);
            drive_side_inputs();
        end while (!in_ready);
    endtask

    // Waits until every expected commit has been seen.
    task automatic drain_pipeline();
        int cycles;
        in_pass      <= '0;
        ready_random = 1'b0;
        flush_enable = 1'b0;
        flush_at     = -1;
        cycles       = 0;
        while (cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            if (expected.size() == 0) begin
                break;
            end
            @(posedge clk);
            drive_side_inputs();
            cycles++;
        end
        if (cycles >= DRAIN_LIMIT) begin
            errors++;
            $display("Pipeline did not drain, %0d items never committed", expected.size());
        end
        @(posedge clk);
        drive_side_inputs();
    endtask

    task automatic run_stream(input int mode, input int count, input bit rdy_rand,
                              input bit flush_en);
        ready_random = rdy_rand;
        flush_enable = flush_en;
        flush_at     = flush_en ? 3 + int'(take_bits(4)) : -1;
        for (int i = 0; i < count; i++) begin
            send_item(make_item(mode, i));
        end
        drain_pipeline();
    endtask

    task automatic sweep_regs(input bit vs_zero);
        for (int i = 0; i < `CPU_NREGS; i++) begin
            raddr_a <= IDX_W'(i);
            raddr_b <= IDX_W'(`CPU_NREGS - 1 - i);
            @(posedge clk);
            check_value("rdata_a", rdata_a, vs_zero ? '0 : mirror[i]);
            check_value("rdata_b", rdata_b, vs_zero ? '0 : mirror[`CPU_NREGS - 1 - i]);
        end
    endtask

    task automatic report_test(input string name, input int start);
        $display("%s: %0d errors", name, total_errors() - start);
    endtask

    // The reference model and the read-port checks run on every edge.
    always @(posedge clk) begin : monitor
        cpu_pkg::commit_t exp_c;
        if (rst_n) begin
            check_value("rdata_a", rdata_a, mirror[raddr_a]);
            check_value("rdata_b", rdata_b, mirror[raddr_b]);
            if (flush) begin
                check_value("commit_valid", 32'(commit_valid), 32'h0);
                expected.delete();
            end else begin
                if (commit_valid && commit_ready) begin
                    if (expected.size() == 0) begin
                        errors++;
                        $display("Commit of pc %h arrived with no item expected", commit.pc);
                    end else begin
                        exp_c = expected.pop_front();
                        check_value("commit.pc", commit.pc, exp_c.pc);
                        check_value("commit.wen", 32'(commit.wen), 32'(exp_c.wen));
                        check_value("commit.wdest", 32'(commit.wdest), 32'(exp_c.wdest));
                        check_value("commit.wdata", commit.wdata, exp_c.wdata);
                    end
                    if (commit.wen && commit.wdest != '0) begin
                        mirror[commit.wdest] = commit.wdata;
                    end
                end
                if (in_pass.valid && in_ready) begin
                    expected.push_back(model_commit(in_pass));
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        int start;
        clk          = 1'b0;
        rst_n        = 1'b0;
        flush        = 1'b0;
        in_pass      = '0;
        commit_ready = 1'b1;
        raddr_a      = '0;
        raddr_b      = '0;
        lfsr_state   = 32'(LFSR_SEED);
        next_pc      = 32'h1c00_0000;
        checks       = 0;
        errors       = 0;
        ready_random = 1'b0;
        flush_enable = 1'b0;
        flush_at     = -1;
        for (int i = 0; i < `CPU_NREGS; i++) begin
            mirror[i] = '0;
        end

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        start = total_errors();
        check_value("commit_valid", 32'(commit_valid), 32'h0);
        check_value("in_ready", 32'(in_ready), 32'h1);
        sweep_regs(1'b1);
        report_test("reset state", start);

        start = total_errors();
        run_stream(MODE_ALU, N_ALU, 1'b0, 1'b0);
        sweep_regs(1'b0);
        report_test("alu results", start);

        start = total_errors();
        run_stream(MODE_LOAD, N_LOAD, 1'b0, 1'b0);
        report_test("loads", start);

        start = total_errors();
        run_stream(MODE_LINK, N_LINK, 1'b0, 1'b0);
        raddr_a <= '0;
        @(posedge clk);
        check_value("rdata_a", rdata_a, 32'h0);
        report_test("link writes", start);

        start = total_errors();
        run_stream(MODE_MIXED, N_BP, 1'b1, 1'b0);
        report_test("back-pressure", start);

        start = total_errors();
        run_stream(MODE_MIXED, N_FLUSH, 1'b1, 1'b1);
        sweep_regs(1'b0);
        report_test("flush", start);

        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, assert_errors());
        if (total_errors() == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- dv/cpu_backend_assert.sv
`timescale 1ns/1ps
`include "cpu_defs_macros.svh"

module cpu_backend_assert (
    input logic                      clk,
    input logic                      rst_n,
    input cpu_pkg::ex_mem2_pass_t    in_pass,
    input logic                      in_ready,
    input logic                      commit_valid,
    input cpu_pkg::commit_t          commit,
    input logic                      commit_ready,
    input logic [`CPU_REG_IDX_W-1:0] raddr_a,
    input logic [`CPU_XLEN-1:0]      rdata_a
);

    // Failure counts of the assertions below.
    int unsigned in_hold_errors     = 0;
    int unsigned commit_hold_errors = 0;
    int unsigned reg_write_errors   = 0;
    int unsigned r0_errors          = 0;

    logic write_to_a;

    // Set when the commit taken at this edge writes the register read on port a.
    assign write_to_a = commit_valid && commit_ready && commit.wen
                        && (commit.wdest == raddr_a);

    // A stalled input item must not change until it is taken.
    in_pass_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (in_pass.valid && !in_ready) |=> $stable(in_pass)
    ) else begin
        $error("in_pass changed while stalled");
        in_hold_errors++;
    end

    commit_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (commit_valid && !commit_ready) |=> $stable(commit)
    ) else begin
        $error("commit record changed while back-pressured");
        commit_hold_errors++;
    end

    // A register seen on port a changes only after a commit that writes it.
    write_on_commit: assert property (
        @(posedge clk) disable iff (!rst_n)
        ($stable(raddr_a) && !$past(write_to_a)) |-> $stable(rdata_a)
    ) else begin
        $error("register changed without a commit");
        reg_write_errors++;
    end

    r0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        (raddr_a == '0) |-> (rdata_a == '0)
    ) else begin
        $error("r0 read back a nonzero value");
        r0_errors++;
    end

endmodule

//--- src/cpu_backend.sv
`timescale 1ns/1ps
`include "cpu_defs_macros.svh"

module cpu_backend (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush,
    input  cpu_pkg::ex_mem2_pass_t    in_pass,
    output logic                      in_ready,
    output logic                      commit_valid,
    output cpu_pkg::commit_t          commit,
    input  logic                      commit_ready,
    input  logic [`CPU_REG_IDX_W-1:0] raddr_a,
    input  logic [`CPU_REG_IDX_W-1:0] raddr_b,
    output logic [`CPU_XLEN-1:0]      rdata_a,
    output logic [`CPU_XLEN-1:0]      rdata_b
);

    cpu_pkg::mem2_wb_pass_t m2_wb_pass;

    logic                      wb_rdy_in;
    logic                      reg_we;
    logic [`CPU_REG_IDX_W-1:0] reg_idx;
    logic [`CPU_XLEN-1:0]      reg_data;

    memory2_stage memory2_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .pass_in     (in_pass),
        .rdy_in      (in_ready),
        .next_rdy_in (wb_rdy_in),
        .pass_out    (m2_wb_pass)
    );

    writeback_stage writeback_stage_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .pass_in      (m2_wb_pass),
        .rdy_in       (wb_rdy_in),
        .next_rdy_in  (commit_ready),
        .reg_idx      (reg_idx),
        .reg_we       (reg_we),
        .reg_data     (reg_data),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    regfile regfile_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (reg_we),
        .waddr   (reg_idx),
        .wdata   (reg_data),
        .raddr_a (raddr_a),
        .raddr_b (raddr_b),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

endmodule

//--- src/regfile.sv
`timescale 1ns/1ps
`include "cpu_defs_macros.svh"

module regfile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      we,
    input  logic [`CPU_REG_IDX_W-1:0] waddr,
    input  logic [`CPU_XLEN-1:0]      wdata,
    input  logic [`CPU_REG_IDX_W-1:0] raddr_a,
    input  logic [`CPU_REG_IDX_W-1:0] raddr_b,
    output logic [`CPU_XLEN-1:0]      rdata_a,
    output logic [`CPU_XLEN-1:0]      rdata_b
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NREGS];

    // r0 is cleared by reset and never written, so it always reads zero.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // No bypass from the write port.
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

//--- src/writeback_stage.sv
`timescale 1ns/1ps
`include "cpu_defs_macros.svh"

module writeback_stage (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      flush,
    input  cpu_pkg::mem2_wb_pass_t    pass_in,
    output logic                      rdy_in,
    input  logic                      next_rdy_in,
    output logic [`CPU_REG_IDX_W-1:0] reg_idx,
    output logic                      reg_we,
    output logic [`CPU_XLEN-1:0]      reg_data,
    output logic                      commit_valid,
    output cpu_pkg::commit_t          commit
);

    cpu_pkg::mem2_wb_pass_t pass_in_r;

    logic                 wb_bubble;
    logic [`CPU_XLEN-1:0] pc_plus4;
    logic [`CPU_XLEN-1:0] result;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pass_in_r.valid <= 1'b0;
        end else if (rdy_in) begin
            pass_in_r <= pass_in;
        end
    end

    // A flushed or empty register holds nothing worth keeping, so it
    // is always ready to be overwritten.
    assign wb_bubble = flush | ~pass_in_r.valid;
    assign rdy_in    = wb_bubble | next_rdy_in;

    assign pc_plus4 = pass_in_r.pc + `CPU_XLEN'd4;
    assign result   = pass_in_r.is_link ? pc_plus4 : pass_in_r.ex_mem_out;

    // commit_valid must not look at commit_ready.
    assign commit_valid = ~wb_bubble;

    // The register file is written only when the commit is taken.
    assign reg_we   = commit_valid & next_rdy_in & pass_in_r.is_wr_rd;
    assign reg_idx  = pass_in_r.rd;
    assign reg_data = result;

    always_comb begin
        commit.pc    = pass_in_r.pc;
        commit.wen   = pass_in_r.is_wr_rd;
        commit.wdest = pass_in_r.rd;
        commit.wdata = result;
    end

endmodule

//--- src/memory2_stage.sv
`timescale 1ns/1ps
`include "cpu_defs_macros.svh"

module memory2_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,
    input  cpu_pkg::ex_mem2_pass_t pass_in,
    output logic                   rdy_in,
    input  logic                   next_rdy_in,
    output cpu_pkg::mem2_wb_pass_t pass_out
);

    cpu_pkg::ex_mem2_pass_t pass_in_r;

    logic [7:0]           ld_byte;
    logic [15:0]          ld_half;
    logic [`CPU_XLEN-1:0] ex_mem_out;

    // Only valid is cleared, the rest of the pass is payload.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pass_in_r.valid <= 1'b0;
        end else if (flush) begin
            pass_in_r.valid <= 1'b0;
        end else if (rdy_in) begin
            pass_in_r <= pass_in;
        end
    end

    // The register can take a new item when it is empty or when
    // writeback takes the current one at this edge.
    assign rdy_in = ~pass_in_r.valid | next_rdy_in;

    // Little-endian lanes: addr_lo 0 selects bits 7:0.
    always_comb begin
        case (pass_in_r.addr_lo)
            2'd0:    ld_byte = pass_in_r.ld_word[7:0];
            2'd1:    ld_byte = pass_in_r.ld_word[15:8];
            2'd2:    ld_byte = pass_in_r.ld_word[23:16];
            default: ld_byte = pass_in_r.ld_word[31:24];
        endcase
    end

    // Halves follow addr_lo[1]; bit 0 is ignored.
    assign ld_half = pass_in_r.addr_lo[1] ? pass_in_r.ld_word[31:16]
                                          : pass_in_r.ld_word[15:0];

    always_comb begin
        case (pass_in_r.ld_kind)
            cpu_pkg::LD_B: begin
                ex_mem_out = {{(`CPU_XLEN - 8){ld_byte[7]}}, ld_byte};
            end
            cpu_pkg::LD_BU: begin
                ex_mem_out = {{(`CPU_XLEN - 8){1'b0}}, ld_byte};
            end
            cpu_pkg::LD_H: begin
                ex_mem_out = {{(`CPU_XLEN - 16){ld_half[15]}}, ld_half};
            end
            cpu_pkg::LD_HU: begin
                ex_mem_out = {{(`CPU_XLEN - 16){1'b0}}, ld_half};
            end
            cpu_pkg::LD_W: begin
                ex_mem_out = pass_in_r.ld_word;
            end
            default: begin
                // Non-load, the execute result goes through.
                ex_mem_out = pass_in_r.ex_out;
            end
        endcase
    end

    // A flush turns the item leaving this stage into a bubble so that
    // writeback does not pick it up at the flush edge.
    always_comb begin
        pass_out.valid      = pass_in_r.valid & ~flush;
        pass_out.pc         = pass_in_r.pc;
        pass_out.rd         = pass_in_r.rd;
        pass_out.is_wr_rd   = pass_in_r.is_wr_rd;
        pass_out.is_link    = pass_in_r.is_link;
        pass_out.ex_mem_out = ex_mem_out;
    end

endmodule

//--- src/cpu_pkg.sv
`include "cpu_defs_macros.svh"

package cpu_pkg;

    // Load kind carried with each instruction. LD_NONE marks a non-load.
    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_B    = 3'd1,
        LD_BU   = 3'd2,
        LD_H    = 3'd3,
        LD_HU   = 3'd4,
        LD_W    = 3'd5
    } ld_kind_t;

    // Execute/memory1 to memory2. For loads ex_out is the address and
    // ld_word the raw word returned by the data cache.
    typedef struct packed {
        logic                      valid;
        logic [`CPU_XLEN-1:0]      pc;
        logic [`CPU_REG_IDX_W-1:0] rd;
        logic                      is_wr_rd;
        logic                      is_link;
        ld_kind_t                  ld_kind;
        logic [1:0]                addr_lo;
        logic [`CPU_XLEN-1:0]      ex_out;
        logic [`CPU_XLEN-1:0]      ld_word;
    } ex_mem2_pass_t;

    // Memory2 to writeback.
    typedef struct packed {
        logic                      valid;
        logic [`CPU_XLEN-1:0]      pc;
        logic [`CPU_REG_IDX_W-1:0] rd;
        logic                      is_wr_rd;
        logic                      is_link;
        logic [`CPU_XLEN-1:0]      ex_mem_out;
    } mem2_wb_pass_t;

    // One committed instruction as seen at the commit port.
    typedef struct packed {
        logic [`CPU_XLEN-1:0]      pc;
        logic                      wen;
        logic [`CPU_REG_IDX_W-1:0] wdest;
        logic [`CPU_XLEN-1:0]      wdata;
    } commit_t;

endpackage

//--- src/cpu_defs_macros.svh
`ifndef CPU_DEFS_MACROS_SVH
`define CPU_DEFS_MACROS_SVH

// Architectural register count of the integer register file.
`define CPU_NREGS 32

// Width of a register index, enough to address CPU_NREGS entries.
`define CPU_REG_IDX_W 5

// Data path width.
`define CPU_XLEN 32

`endif
